//--- Bender.yml
package:
  name: mips_core

sources:
  - rtl/mips_pkg.sv
  - rtl/instr_fetch.sv
  - rtl/reg_file.sv
  - rtl/instr_decode.sv
  - rtl/alu_execute.sv
  - rtl/mips_core.sv
  - target: test
    files:
      - tests/tb_mips_core.sv

//--- mips_core.f
rtl/mips_pkg.sv
rtl/instr_fetch.sv
rtl/reg_file.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/mips_core.sv
tests/tb_mips_core.sv

//--- rtl/alu_execute.sv
`timescale 1ns/1ns
`default_nettype none

module alu_execute (
    input  logic                i_clock,
    input  logic                i_arst_n,
    input  logic                i_id_valid,
    input  mips_pkg::alu_op_e   i_id_alu_op,
    input  logic                i_id_use_imm,
    input  logic                i_id_wr_en,
    input  mips_pkg::reg_addr_t i_id_dest,
    input  mips_pkg::reg_addr_t i_id_rs,
    input  mips_pkg::reg_addr_t i_id_rt,
    input  mips_pkg::word_t     i_id_rs_data,
    input  mips_pkg::word_t     i_id_rt_data,
    input  mips_pkg::word_t     i_id_imm,
    input  mips_pkg::shamt_t    i_id_shamt,
    output logic                o_ex_valid,
    output logic                o_ex_wr_en,
    output mips_pkg::reg_addr_t o_ex_dest,
    output mips_pkg::word_t     o_ex_result
);

    mips_pkg::word_t op_rs;
    mips_pkg::word_t op_rt;
    mips_pkg::word_t op_b;
    mips_pkg::word_t alu_result;

    // Take the EX/WB result when it targets this source
    assign op_rs = (o_ex_valid && o_ex_wr_en && o_ex_dest == i_id_rs) ?
        o_ex_result : i_id_rs_data;
    assign op_rt = (o_ex_valid && o_ex_wr_en && o_ex_dest == i_id_rt) ?
        o_ex_result : i_id_rt_data;
    assign op_b  = i_id_use_imm ? i_id_imm : op_rt;

    always_comb begin
        case (i_id_alu_op)
            mips_pkg::ALU_ADD: alu_result = op_rs + op_b;
            mips_pkg::ALU_SUB: alu_result = op_rs - op_b;
            mips_pkg::ALU_AND: alu_result = op_rs & op_b;
            mips_pkg::ALU_OR:  alu_result = op_rs | op_b;
            mips_pkg::ALU_XOR: alu_result = op_rs ^ op_b;
            mips_pkg::ALU_NOR: alu_result = ~(op_rs | op_b);
            mips_pkg::ALU_SLT: alu_result = mips_pkg::word_t'($signed(op_rs) < $signed(op_b));
            // Shifts act on rt
            mips_pkg::ALU_SLL: alu_result = op_rt << i_id_shamt;
            mips_pkg::ALU_SRL: alu_result = op_rt >> i_id_shamt;
            mips_pkg::ALU_LUI: alu_result = {i_id_imm[mips_pkg::IMM_W-1:0],
                                             {(mips_pkg::DATA_W-mips_pkg::IMM_W){1'b0}}};
            default:           alu_result = '0;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ex_valid <= 1'b0;
            o_ex_wr_en <= 1'b0;
        end else begin
            o_ex_valid <= i_id_valid;
            o_ex_wr_en <= i_id_valid && i_id_wr_en;
        end
    end

    always_ff @(posedge i_clock) begin
        o_ex_dest   <= i_id_dest;
        o_ex_result <= alu_result;
    end

endmodule

`default_nettype wire

//--- rtl/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
    input  logic                i_clock,
    input  logic                i_arst_n,
    input  logic                i_if_valid,
    input  mips_pkg::word_t     i_if_instr,
    input  mips_pkg::word_t     i_rs_data,
    input  mips_pkg::word_t     i_rt_data,
    output mips_pkg::reg_addr_t o_rs_addr,
    output mips_pkg::reg_addr_t o_rt_addr,
    output logic                o_id_valid,
    output mips_pkg::alu_op_e   o_id_alu_op,
    output logic                o_id_use_imm,
    output logic                o_id_wr_en,
    output mips_pkg::reg_addr_t o_id_dest,
    output mips_pkg::reg_addr_t o_id_rs,
    output mips_pkg::reg_addr_t o_id_rt,
    output mips_pkg::word_t     o_id_rs_data,
    output mips_pkg::word_t     o_id_rt_data,
    output mips_pkg::word_t     o_id_imm,
    output mips_pkg::shamt_t    o_id_shamt
);

    logic [5:0]          opcode;
    logic [5:0]          funct;
    mips_pkg::reg_addr_t rd;
    mips_pkg::imm_t      imm;
    mips_pkg::shamt_t    shamt;

    mips_pkg::alu_op_e   dec_alu_op;
    logic                dec_use_imm;
    logic                dec_known;
    logic                dec_sign_ext;
    logic                dec_wr_en;
    mips_pkg::reg_addr_t dec_dest;
    mips_pkg::word_t     dec_imm;

    assign opcode    = i_if_instr[31:26];
    assign o_rs_addr = i_if_instr[25:21];
    assign o_rt_addr = i_if_instr[20:16];
    assign rd        = i_if_instr[15:11];
    assign shamt     = i_if_instr[10:6];
    assign funct     = i_if_instr[5:0];
    assign imm       = i_if_instr[15:0];

    always_comb begin
        dec_alu_op   = mips_pkg::ALU_ADD;
        dec_use_imm  = 1'b1;
        dec_known    = 1'b1;
        dec_sign_ext = 1'b0;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                dec_use_imm = 1'b0;
                case (funct)
                    mips_pkg::FN_ADDU: dec_alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: dec_alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  dec_alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   dec_alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  dec_alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  dec_alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT:  dec_alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL:  dec_alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  dec_alu_op = mips_pkg::ALU_SRL;
                    default:           dec_known  = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                dec_alu_op   = mips_pkg::ALU_ADD;
                dec_sign_ext = 1'b1;
            end
            mips_pkg::OP_SLTI: begin
                dec_alu_op   = mips_pkg::ALU_SLT;
                dec_sign_ext = 1'b1;
            end
            mips_pkg::OP_ANDI: dec_alu_op = mips_pkg::ALU_AND;
            mips_pkg::OP_ORI:  dec_alu_op = mips_pkg::ALU_OR;
            mips_pkg::OP_XORI: dec_alu_op = mips_pkg::ALU_XOR;
            mips_pkg::OP_LUI:  dec_alu_op = mips_pkg::ALU_LUI;
            default:           dec_known  = 1'b0;
        endcase
    end

    // rd for R-type, rt otherwise; no write to r0
    assign dec_dest  = (opcode == mips_pkg::OP_RTYPE) ? rd : o_rt_addr;
    assign dec_wr_en = dec_known && (dec_dest != '0);
    assign dec_imm   = dec_sign_ext ?
        {{(mips_pkg::DATA_W-mips_pkg::IMM_W){imm[mips_pkg::IMM_W-1]}}, imm} :
        {{(mips_pkg::DATA_W-mips_pkg::IMM_W){1'b0}}, imm};

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_valid <= 1'b0;
            o_id_wr_en <= 1'b0;
        end else begin
            o_id_valid <= i_if_valid;
            o_id_wr_en <= i_if_valid && dec_wr_en;
        end
    end

    always_ff @(posedge i_clock) begin
        o_id_alu_op  <= dec_alu_op;
        o_id_use_imm <= dec_use_imm;
        o_id_dest    <= dec_dest;
        o_id_rs      <= o_rs_addr;
        o_id_rt      <= o_rt_addr;
        o_id_rs_data <= i_rs_data;
        o_id_rt_data <= i_rt_data;
        o_id_imm     <= dec_imm;
        o_id_shamt   <= shamt;
    end

endmodule

`default_nettype wire

//--- rtl/instr_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module instr_fetch (
    input  logic                i_clock,
    input  logic                i_arst_n,
    input  logic                i_run,
    input  logic                i_load_valid,
    input  mips_pkg::byte_t     i_load_byte,
    output logic                o_load_ready,
    output logic                o_if_valid,
    output mips_pkg::word_t     o_if_instr
);

    localparam int CNT_W = mips_pkg::PC_W + 3;

    mips_pkg::word_t mem [mips_pkg::IMEM_WORDS];
    mips_pkg::word_t word_buf;
    mips_pkg::word_t fetch_word;
    mips_pkg::pc_t   pc;

    // Byte count; the top bit marks a full memory
    logic [CNT_W-1:0] load_cnt;
    logic             load_full;
    logic             load_fire;

    assign load_full    = load_cnt[CNT_W-1];
    assign o_load_ready = !i_run && !load_full;
    assign load_fire    = i_load_valid && o_load_ready;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            load_cnt <= '0;
        end else if (load_fire) begin
            load_cnt <= load_cnt + 1'b1;
        end
    end

    // Little-endian assembly, the last byte of a word commits it
    always_ff @(posedge i_clock) begin
        if (load_fire) begin
            word_buf <= {i_load_byte, word_buf[mips_pkg::DATA_W-1:mips_pkg::BYTE_W]};
            if (load_cnt[1:0] == 2'd3) begin
                mem[load_cnt[CNT_W-2:2]] <=
                    {i_load_byte, word_buf[mips_pkg::DATA_W-1:mips_pkg::BYTE_W]};
            end
        end
    end

    // Words never loaded fetch as zero
    assign fetch_word = ({1'b0, pc} < load_cnt[CNT_W-1:2]) ? mem[pc] : '0;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc         <= '0;
            o_if_valid <= 1'b0;
        end else begin
            o_if_valid <= i_run;
            if (i_run) begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run) begin
            o_if_instr <= fetch_word;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core (
    input  logic                i_clock,
    input  logic                i_arst_n,
    input  logic                i_run,
    input  logic                i_load_valid,
    input  mips_pkg::byte_t     i_load_byte,
    output logic                o_load_ready,
    output logic                o_wb_valid,
    output mips_pkg::reg_addr_t o_wb_reg,
    output mips_pkg::word_t     o_wb_data
);

    // IF/ID
    logic                if_valid;
    mips_pkg::word_t     if_instr;

    // Register file read
    mips_pkg::reg_addr_t rs_addr;
    mips_pkg::reg_addr_t rt_addr;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;

    // ID/EX
    logic                id_valid;
    mips_pkg::alu_op_e   id_alu_op;
    logic                id_use_imm;
    logic                id_wr_en;
    mips_pkg::reg_addr_t id_dest;
    mips_pkg::reg_addr_t id_rs;
    mips_pkg::reg_addr_t id_rt;
    mips_pkg::word_t     id_rs_data;
    mips_pkg::word_t     id_rt_data;
    mips_pkg::word_t     id_imm;
    mips_pkg::shamt_t    id_shamt;

    // EX/WB
    logic                ex_valid;
    logic                ex_wr_en;
    mips_pkg::reg_addr_t ex_dest;
    mips_pkg::word_t     ex_result;

    assign o_wb_valid = ex_valid && ex_wr_en;
    assign o_wb_reg   = ex_dest;
    assign o_wb_data  = ex_result;

    instr_fetch instr_fetch_inst (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .i_run        (i_run),
        .i_load_valid (i_load_valid),
        .i_load_byte  (i_load_byte),
        .o_load_ready (o_load_ready),
        .o_if_valid   (if_valid),
        .o_if_instr   (if_instr)
    );

    instr_decode instr_decode_inst (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .i_if_valid   (if_valid),
        .i_if_instr   (if_instr),
        .i_rs_data    (rs_data),
        .i_rt_data    (rt_data),
        .o_rs_addr    (rs_addr),
        .o_rt_addr    (rt_addr),
        .o_id_valid   (id_valid),
        .o_id_alu_op  (id_alu_op),
        .o_id_use_imm (id_use_imm),
        .o_id_wr_en   (id_wr_en),
        .o_id_dest    (id_dest),
        .o_id_rs      (id_rs),
        .o_id_rt      (id_rt),
        .o_id_rs_data (id_rs_data),
        .o_id_rt_data (id_rt_data),
        .o_id_imm     (id_imm),
        .o_id_shamt   (id_shamt)
    );

    reg_file reg_file_inst (
        .i_clock   (i_clock),
        .i_arst_n  (i_arst_n),
        .i_rs_addr (rs_addr),
        .i_rt_addr (rt_addr),
        .i_wr_en   (o_wb_valid),
        .i_wr_addr (ex_dest),
        .i_wr_data (ex_result),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    alu_execute alu_execute_inst (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .i_id_valid   (id_valid),
        .i_id_alu_op  (id_alu_op),
        .i_id_use_imm (id_use_imm),
        .i_id_wr_en   (id_wr_en),
        .i_id_dest    (id_dest),
        .i_id_rs      (id_rs),
        .i_id_rt      (id_rt),
        .i_id_rs_data (id_rs_data),
        .i_id_rt_data (id_rt_data),
        .i_id_imm     (id_imm),
        .i_id_shamt   (id_shamt),
        .o_ex_valid   (ex_valid),
        .o_ex_wr_en   (ex_wr_en),
        .o_ex_dest    (ex_dest),
        .o_ex_result  (ex_result)
    );

endmodule

`default_nettype wire

//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Widths
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_WORDS = 64;
    localparam int PC_W       = 6;
    localparam int BYTE_W     = 8;
    localparam int IMM_W      = 16;
    localparam int SHAMT_W    = 5;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [BYTE_W-1:0]     byte_t;
    typedef logic [IMM_W-1:0]      imm_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;

    // Opcodes of the supported subset
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    // R-type function codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

endpackage

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                i_clock,
    input  logic                i_arst_n,
    input  mips_pkg::reg_addr_t i_rs_addr,
    input  mips_pkg::reg_addr_t i_rt_addr,
    input  logic                i_wr_en,
    input  mips_pkg::reg_addr_t i_wr_addr,
    input  mips_pkg::word_t     i_wr_data,
    output mips_pkg::word_t     o_rs_data,
    output mips_pkg::word_t     o_rt_data
);

    mips_pkg::word_t regs [1:31];

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_addr != '0) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Register 0 reads zero and a same-cycle write passes straight through
    assign o_rs_data = (i_rs_addr == '0) ? '0 :
                       (i_wr_en && i_wr_addr == i_rs_addr) ? i_wr_data : regs[i_rs_addr];
    assign o_rt_data = (i_rt_addr == '0) ? '0 :
                       (i_wr_en && i_wr_addr == i_rt_addr) ? i_wr_data : regs[i_rt_addr];

endmodule

`default_nettype wire

//--- tests/tb_mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_core;

    localparam int MAX_TESTS = 32;
    localparam int MAX_GAP   = 2;

    logic                i_clock;
    logic                i_arst_n;
    logic                i_run;
    logic                i_load_valid;
    mips_pkg::byte_t     i_load_byte;
    logic                o_load_ready;
    logic                o_wb_valid;
    mips_pkg::reg_addr_t o_wb_reg;
    mips_pkg::word_t     o_wb_data;

    string               names [MAX_TESTS];
    mips_pkg::word_t     prog [MAX_TESTS];
    logic                exp_wr [MAX_TESTS];
    mips_pkg::reg_addr_t exp_reg [MAX_TESTS];
    mips_pkg::word_t     exp_data [MAX_TESTS];
    mips_pkg::word_t     model_regs [32];
    logic [31:0]         rng;
    int                  n_tests;
    int                  seg_lo;
    int                  seg_len;
    int                  edge_num = 1000;
    logic                run_q = 1'b0;
    int                  n_done = 0;
    int                  n_pass = 0;
    int                  n_fail = 0;
    int                  n_errs = 0;
    int                  cycles = 0;
    int                  cycle_limit;
    int                  k;
    bit                  test_ok;

    mips_core mips_core_inst (.*);

    initial i_clock = 1'b0;
    always #2 i_clock = ~i_clock;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic mips_pkg::word_t rtype(input logic [5:0] fn, input logic [4:0] rd,
                                              input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] sh);
        return {mips_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic mips_pkg::word_t itype(input logic [5:0] op, input logic [4:0] rt,
                                              input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_test(input string name, input mips_pkg::word_t instr, input bit rnd_imm);
        if (rnd_imm) begin
            rng = xorshift(rng);
            instr[15:0] = rng[15:0];
        end
        names[n_tests] = name;
        prog[n_tests]  = instr;
        n_tests++;
    endtask

    // ISA rules of the kept subset, applied in program order
    task automatic model_step(input int idx);
        mips_pkg::word_t     ins;
        mips_pkg::word_t     a;
        mips_pkg::word_t     b;
        mips_pkg::word_t     sx;
        mips_pkg::word_t     zx;
        mips_pkg::reg_addr_t dest;
        logic                known;
        ins   = prog[idx];
        a     = model_regs[ins[25:21]];
        b     = model_regs[ins[20:16]];
        sx    = {{16{ins[15]}}, ins[15:0]};
        zx    = {16'h0, ins[15:0]};
        dest  = ins[20:16];
        known = 1'b1;
        exp_data[idx] = '0;
        case (ins[31:26])
            mips_pkg::OP_RTYPE: begin
                dest = ins[15:11];
                case (ins[5:0])
                    mips_pkg::FN_ADDU: exp_data[idx] = a + b;
                    mips_pkg::FN_SUBU: exp_data[idx] = a - b;
                    mips_pkg::FN_AND:  exp_data[idx] = a & b;
                    mips_pkg::FN_OR:   exp_data[idx] = a | b;
                    mips_pkg::FN_XOR:  exp_data[idx] = a ^ b;
                    mips_pkg::FN_NOR:  exp_data[idx] = ~(a | b);
                    mips_pkg::FN_SLT:  exp_data[idx] = {31'h0, $signed(a) < $signed(b)};
                    mips_pkg::FN_SLL:  exp_data[idx] = b << ins[10:6];
                    mips_pkg::FN_SRL:  exp_data[idx] = b >> ins[10:6];
                    default:           known = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: exp_data[idx] = a + sx;
            mips_pkg::OP_SLTI:  exp_data[idx] = {31'h0, $signed(a) < $signed(sx)};
            mips_pkg::OP_ANDI:  exp_data[idx] = a & zx;
            mips_pkg::OP_ORI:   exp_data[idx] = a | zx;
            mips_pkg::OP_XORI:  exp_data[idx] = a ^ zx;
            mips_pkg::OP_LUI:   exp_data[idx] = {ins[15:0], 16'h0};
            default:            known = 1'b0;
        endcase
        exp_reg[idx] = dest;
        exp_wr[idx]  = known && (dest != 0);
        if (exp_wr[idx]) begin
            model_regs[dest] = exp_data[idx];
        end
    endtask

    // Bytes go out little-endian with random idle gaps
    task automatic load_words(input int lo, input int cnt);
        mips_pkg::word_t w;
        for (int i = lo; i < lo + cnt; i++) begin
            w = prog[i];
            for (int b = 0; b < 4; b++) begin
                rng = xorshift(rng);
                i_load_valid <= 1'b0;
                repeat (rng % (MAX_GAP + 1)) @(posedge i_clock);
                i_load_valid <= 1'b1;
                i_load_byte  <= w[8*b +: 8];
                @(posedge i_clock);
                while (!o_load_ready) @(posedge i_clock);
            end
        end
        i_load_valid <= 1'b0;
    endtask

    // A junk byte is offered all through the run and must not be taken
    task automatic run_words(input int lo, input int cnt);
        seg_lo       <= lo;
        seg_len      <= cnt;
        i_run        <= 1'b1;
        i_load_valid <= 1'b1;
        i_load_byte  <= 8'hee;
        repeat (cnt) @(posedge i_clock);
        i_run        <= 1'b0;
        i_load_valid <= 1'b0;
    endtask

    // Instruction k of a segment owns the writeback slot at run edge k+3
    always @(posedge i_clock) begin
        if (i_run && !run_q) begin
            edge_num = 0;
        end else begin
            edge_num = edge_num + 1;
        end
        run_q = i_run;
        if (i_arst_n) begin
            assert (o_load_ready == !i_run) else begin
                $display("load ready is %b while run is %b", o_load_ready, i_run);
                n_errs++;
            end
            if (edge_num >= 3 && edge_num < seg_len + 3) begin
                k       = seg_lo + edge_num - 3;
                test_ok = 1'b1;
                if (exp_wr[k]) begin
                    assert (o_wb_valid) else begin
                        $display("%s: no writeback in its cycle", names[k]);
                        test_ok = 1'b0;
                    end
                    assert (!o_wb_valid || o_wb_reg == exp_reg[k]) else begin
                        $display("MISMATCH %s reg expected %0d actual %0d",
                                 names[k], exp_reg[k], o_wb_reg);
                        test_ok = 1'b0;
                    end
                    assert (!o_wb_valid || o_wb_data == exp_data[k]) else begin
                        $display("MISMATCH %s data expected %h actual %h",
                                 names[k], exp_data[k], o_wb_data);
                        test_ok = 1'b0;
                    end
                end else begin
                    assert (!o_wb_valid) else begin
                        $display("%s: writes r%0d although it writes no register",
                                 names[k], o_wb_reg);
                        test_ok = 1'b0;
                    end
                end
                $display("test %-10s %s", names[k], test_ok ? "passed" : "failed");
                if (test_ok) begin
                    n_pass++;
                end else begin
                    n_fail++;
                end
                n_done++;
            end else begin
                assert (!o_wb_valid) else begin
                    $display("writeback to r%0d outside any instruction slot", o_wb_reg);
                    n_errs++;
                end
            end
        end
    end

    always @(posedge i_clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, writebacks missing: %0d of %0d tests done",
                     cycles, n_done, n_tests);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        rng          = 32'h40a4_8a7d;
        n_tests      = 0;
        seg_lo       = 0;
        seg_len      = 0;
        i_arst_n     = 1'b0;
        i_run        = 1'b0;
        i_load_valid = 1'b0;
        i_load_byte  = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end

        add_test("lui_r1",    itype(mips_pkg::OP_LUI, 1, 0, 16'h0), 1);
        add_test("ori_r1",    itype(mips_pkg::OP_ORI, 1, 1, 16'h0), 1);
        add_test("lui_r2",    itype(mips_pkg::OP_LUI, 2, 0, 16'h0), 1);
        add_test("ori_r2",    itype(mips_pkg::OP_ORI, 2, 2, 16'h0), 1);
        add_test("addiu_neg", itype(mips_pkg::OP_ADDIU, 3, 0, 16'h8001), 0);
        add_test("addu",      rtype(mips_pkg::FN_ADDU, 4, 1, 2, 0), 0);
        add_test("subu",      rtype(mips_pkg::FN_SUBU, 5, 1, 2, 0), 0);
        add_test("and",       rtype(mips_pkg::FN_AND, 6, 1, 2, 0), 0);
        add_test("or",        rtype(mips_pkg::FN_OR, 7, 1, 2, 0), 0);
        add_test("xor",       rtype(mips_pkg::FN_XOR, 8, 1, 2, 0), 0);
        add_test("nor",       rtype(mips_pkg::FN_NOR, 9, 1, 2, 0), 0);
        add_test("slt",       rtype(mips_pkg::FN_SLT, 10, 3, 1, 0), 0);
        add_test("sll",       rtype(mips_pkg::FN_SLL, 11, 0, 1, 7), 0);
        add_test("srl",       rtype(mips_pkg::FN_SRL, 12, 0, 2, 9), 0);
        add_test("slti_neg",  itype(mips_pkg::OP_SLTI, 13, 0, 16'hfffe), 0);
        add_test("andi",      itype(mips_pkg::OP_ANDI, 14, 1, 16'h8ff0), 0);
        add_test("xori",      itype(mips_pkg::OP_XORI, 15, 2, 16'h8421), 0);
        add_test("addiu_rnd", itype(mips_pkg::OP_ADDIU, 16, 1, 16'h0), 1);
        add_test("addu_fwd",  rtype(mips_pkg::FN_ADDU, 17, 16, 15, 0), 0);
        add_test("wr_r0",     rtype(mips_pkg::FN_ADDU, 0, 1, 2, 0), 0);
        add_test("bad_op",    itype(6'h3f, 18, 1, 16'h1234), 0);
        add_test("bad_fn",    rtype(6'h08, 19, 1, 0, 0), 0);
        add_test("zero_word", 32'h0, 0);
        add_test("or_r0",     rtype(mips_pkg::FN_OR, 20, 0, 17, 0), 0);
        add_test("subu_fwd",  rtype(mips_pkg::FN_SUBU, 21, 1, 20, 0), 0);
        add_test("ori_zext",  itype(mips_pkg::OP_ORI, 22, 0, 16'hc003), 0);

        for (int t = 0; t < n_tests; t++) begin
            model_step(t);
        end
        // Worst-case load gaps, two runs with drain, reset and margin
        cycle_limit = n_tests * 4 * (MAX_GAP + 1) + n_tests + 2 * 3 + 5 + 20;

        repeat (5) @(posedge i_clock);
        i_arst_n <= 1'b1;
        load_words(0, 14);
        run_words(0, 14);
        load_words(14, n_tests - 14);
        run_words(14, n_tests - 14);
        wait (n_done == n_tests);
        repeat (2) @(posedge i_clock);

        $display("tests passed %0d failed %0d, other errors %0d", n_pass, n_fail, n_errs);
        if (n_fail == 0 && n_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
